/* design/bus_agent.sv */
`default_nettype none

module bus_agent (
    input  logic                       clk,
    input  logic                       rst,
    input  mem_pkg::mem_op_e           mem_op,
    input  logic                       hit,
    input  logic [mem_pkg::XLEN-1:0]   addr,
    input  logic [mem_pkg::XLEN-1:0]   store_data,
    input  logic                       a_ready,
    input  logic                       d_valid,
    input  mem_pkg::tl_d_op_e          d_opcode,
    input  logic [mem_pkg::XLEN-1:0]   d_data,
    output logic                       a_valid,
    output mem_pkg::tl_a_op_e          a_opcode,
    output logic [mem_pkg::SIZE_W-1:0] a_size,
    output logic [mem_pkg::XLEN-1:0]   a_address,
    output logic [mem_pkg::XLEN-1:0]   a_data,
    output logic [mem_pkg::XLEN-1:0]   rd_data,
    output logic                       stall
);
    import mem_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAIT,
        DONE
    } state_e;

    state_e state;
    state_e state_next;

    logic              need_bus;
    logic              start;
    logic [WORD_W-1:0] st_word;
    logic [XLEN-1:0]   dw_addr;

    assign need_bus = is_store(mem_op) || (is_load(mem_op) && !hit);
    assign start    = (state == IDLE) && need_bus;
    assign st_word  = store_data[WORD_W-1:0];
    assign dw_addr  = {addr[XLEN-1:OFFSET_W], {OFFSET_W{1'b0}}};

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE: if (need_bus) state_next = REQ;
            REQ:  if (a_ready) state_next = WAIT;
            WAIT: if (d_valid) state_next = DONE;   // d channel is always accepted.
            DONE: state_next = IDLE;   // op is consumed here.
            default: state_next = IDLE;
        endcase
    end

    // stall drops only once the response has been latched.
    always_comb begin
        case (state)
            IDLE:      stall = need_bus;
            REQ, WAIT: stall = 1'b1;
            default:   stall = 1'b0;
        endcase
    end

    assign a_valid = (state == REQ);

    // request fields are captured once, so they stay put under back-pressure.
    always_ff @(posedge clk) begin
        if (start) begin
            if (is_store(mem_op)) begin
                a_opcode <= TL_PUT_FULL;
                if (is_word(mem_op)) begin
                    a_size    <= SIZE_W'(2);
                    a_address <= {addr[XLEN-1:2], 2'b00};
                    // word goes into its byte lane of the doubleword.
                    a_data    <= addr[OFFSET_W-1] ? {st_word, {WORD_W{1'b0}}}
                                                  : {{WORD_W{1'b0}}, st_word};
                end else begin
                    a_size    <= SIZE_W'(3);
                    a_address <= dw_addr;
                    a_data    <= store_data;
                end
            end else begin
                a_opcode  <= TL_GET;
                a_size    <= SIZE_W'(3);   // whole line, word loads too.
                a_address <= dw_addr;
                a_data    <= '0;
            end
        end
    end

    // response data for the load miss.
    always_ff @(posedge clk) begin
        if ((state == WAIT) && d_valid && (d_opcode == TL_ACK_DATA)) begin
            rd_data <= d_data;
        end
    end

endmodule

`default_nettype wire

/* design/data_cache.sv */
`default_nettype none

module data_cache (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     invalid,
    input  mem_pkg::mem_op_e         mem_op,
    input  logic [mem_pkg::XLEN-1:0] addr,
    input  logic [mem_pkg::XLEN-1:0] store_data,
    input  logic                     d_valid,
    input  mem_pkg::tl_d_op_e        d_opcode,
    input  logic [mem_pkg::XLEN-1:0] d_data,
    output logic [mem_pkg::XLEN-1:0] rd_data,
    output logic                     hit
);
    import mem_pkg::*;

    logic [TAG_W-1:0]       tag_mem  [CACHE_LINES];
    logic [XLEN-1:0]        data_mem [CACHE_LINES];
    logic [CACHE_LINES-1:0] valid;

    logic [INDEX_W-1:0] index;
    logic [TAG_W-1:0]   tag;
    logic               tag_match;
    logic               fill;
    logic               store_upd;
    logic [XLEN-1:0]    merged;

    assign index = addr[OFFSET_W +: INDEX_W];
    assign tag   = addr[XLEN-1 -: TAG_W];

    assign tag_match = valid[index] && (tag_mem[index] == tag);
    assign hit       = is_load(mem_op) && tag_match;   // stores never count as hits.
    assign rd_data   = data_mem[index];

    // d_ready is always high, so d_valid alone marks a beat.
    assign fill      = d_valid && (d_opcode == TL_ACK_DATA);
    assign store_upd = d_valid && (d_opcode == TL_ACK) && is_store(mem_op) && tag_match;

    // write-through update of a line that is already present.
    always_comb begin
        merged = data_mem[index];
        if (is_word(mem_op)) begin
            if (addr[OFFSET_W-1]) begin
                merged[XLEN-1:WORD_W] = store_data[WORD_W-1:0];   // upper lane.
            end else begin
                merged[WORD_W-1:0] = store_data[WORD_W-1:0];
            end
        end else begin
            merged = store_data;
        end
    end

    // flush wins over a fill in the same cycle.
    always_ff @(posedge clk) begin
        if (rst || invalid) begin
            valid <= '0;
        end else if (fill) begin
            valid[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            tag_mem[index]  <= tag;
            data_mem[index] <= d_data;
        end else if (store_upd) begin
            data_mem[index] <= merged;
        end
    end

endmodule

`default_nettype wire

/* design/ma_wb_reg.sv */
`default_nettype none

module ma_wb_reg (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     clear,
    input  logic                     trap_en,
    input  logic                     stall,
    input  logic [mem_pkg::XLEN-1:0] pc,
    input  logic [4:0]               rd,
    input  logic [mem_pkg::XLEN-1:0] data,
    output logic [mem_pkg::XLEN-1:0] pc_out,
    output logic [4:0]               rd_out,
    output logic [mem_pkg::XLEN-1:0] data_out
);

    logic bubble;

    assign bubble = clear || trap_en;

    // rd 0 marks an empty slot for write-back.
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_out <= '0;
        end else if (!stall) begin
            rd_out <= bubble ? 5'd0 : rd;
        end
    end

    // held under stall so WB keeps forwarding the same value.
    always_ff @(posedge clk) begin
        if (!stall) begin
            pc_out   <= pc;
            data_out <= bubble ? '0 : data;
        end
    end

endmodule

`default_nettype wire

/* design/mem_access.sv */
`default_nettype none

module mem_access (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       clear,
    input  logic                       trap_en,
    input  mem_pkg::mem_op_e           mem_op,
    input  logic [mem_pkg::XLEN-1:0]   pc,
    input  logic [4:0]                 rd,
    input  logic [mem_pkg::XLEN-1:0]   result,
    input  logic [mem_pkg::XLEN-1:0]   data2,
    input  logic [mem_pkg::XLEN-1:0]   csr_data,
    input  logic                       op_csr,
    input  logic                       invalid,
    output logic [mem_pkg::XLEN-1:0]   ma_out,
    output logic [mem_pkg::XLEN-1:0]   pc_out,
    output logic [4:0]                 rd_out,
    output logic [mem_pkg::XLEN-1:0]   data_out,
    output logic                       stall,
    output logic                       a_valid,
    output mem_pkg::tl_a_op_e          a_opcode,
    output logic [mem_pkg::SIZE_W-1:0] a_size,
    output logic [mem_pkg::XLEN-1:0]   a_address,
    output logic [mem_pkg::XLEN-1:0]   a_data,
    input  logic                       a_ready,
    input  logic                       d_valid,
    input  mem_pkg::tl_d_op_e          d_opcode,
    input  logic [mem_pkg::XLEN-1:0]   d_data
);
    import mem_pkg::*;

    logic [XLEN-1:0]   cache_data;
    logic [XLEN-1:0]   bus_data;
    logic              cache_hit;
    logic [XLEN-1:0]   mem_dword;
    logic [WORD_W-1:0] mem_word;
    logic [XLEN-1:0]   load_val;

    // cache first, bus data covers a flush that raced the fill.
    assign mem_dword = cache_hit ? cache_data : bus_data;
    assign mem_word  = result[OFFSET_W-1] ? mem_dword[XLEN-1:WORD_W] : mem_dword[WORD_W-1:0];

    always_comb begin
        case (mem_op)
            MEM_LD:  load_val = mem_dword;
            MEM_LW:  load_val = {{WORD_W{mem_word[WORD_W-1]}}, mem_word};   // sign extend.
            MEM_LWU: load_val = {{WORD_W{1'b0}}, mem_word};
            default: load_val = result;   // alu value passes through.
        endcase
    end

    assign ma_out = op_csr ? csr_data : load_val;

    data_cache u_data_cache (
        .clk        (clk),
        .rst        (rst),
        .invalid    (invalid),
        .mem_op     (mem_op),
        .addr       (result),
        .store_data (data2),
        .d_valid    (d_valid),
        .d_opcode   (d_opcode),
        .d_data     (d_data),
        .rd_data    (cache_data),
        .hit        (cache_hit)
    );

    bus_agent u_bus_agent (
        .clk        (clk),
        .rst        (rst),
        .mem_op     (mem_op),
        .hit        (cache_hit),
        .addr       (result),
        .store_data (data2),
        .a_ready    (a_ready),
        .d_valid    (d_valid),
        .d_opcode   (d_opcode),
        .d_data     (d_data),
        .a_valid    (a_valid),
        .a_opcode   (a_opcode),
        .a_size     (a_size),
        .a_address  (a_address),
        .a_data     (a_data),
        .rd_data    (bus_data),
        .stall      (stall)
    );

    // stall also freezes write-back, EX may forward from it.
    ma_wb_reg u_ma_wb_reg (
        .clk      (clk),
        .rst      (rst),
        .clear    (clear),
        .trap_en  (trap_en),
        .stall    (stall),
        .pc       (pc),
        .rd       (rd),
        .data     (ma_out),
        .pc_out   (pc_out),
        .rd_out   (rd_out),
        .data_out (data_out)
    );

endmodule

`default_nettype wire

/* design/mem_pkg.sv */
`default_nettype none

package mem_pkg;

    localparam int XLEN        = 64;
    localparam int WORD_W      = XLEN / 2;
    localparam int CACHE_LINES = 8;   // one doubleword per line.
    localparam int INDEX_W     = 3;
    localparam int OFFSET_W    = 3;
    localparam int TAG_W       = XLEN - INDEX_W - OFFSET_W;
    localparam int SIZE_W      = 3;   // log2 of the transfer bytes.

    // operation sitting in the MA stage.
    typedef enum logic [2:0] {
        MEM_NONE,
        MEM_LD,
        MEM_LW,
        MEM_LWU,
        MEM_SD,
        MEM_SW
    } mem_op_e;

    typedef enum logic [2:0] {
        TL_PUT_FULL = 3'd0,
        TL_GET      = 3'd4
    } tl_a_op_e;

    typedef enum logic [2:0] {
        TL_ACK      = 3'd0,
        TL_ACK_DATA = 3'd1
    } tl_d_op_e;

    function automatic logic is_load(mem_op_e op);
        return op inside {MEM_LD, MEM_LW, MEM_LWU};
    endfunction

    function automatic logic is_store(mem_op_e op);
        return op inside {MEM_SD, MEM_SW};
    endfunction

    // word sized ops, loads and stores alike.
    function automatic logic is_word(mem_op_e op);
        return op inside {MEM_LW, MEM_LWU, MEM_SW};
    endfunction

endpackage

`default_nettype wire

/* run.sh */
#!/bin/sh
# build the testbench with verilator and run it from the project root.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir

verilator --binary --timing -f tb.f --top-module tb_mem_access -o sim_mem_access \
    > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_mem_access > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Test OK$" sim.log; then
    exit 0
fi
exit 1

/* tb.f */
design/mem_pkg.sv
design/data_cache.sv
design/bus_agent.sv
design/ma_wb_reg.sv
design/mem_access.sv
tb/tl_mem_model.sv
tb/tb_mem_access.sv

/* tb/tb_mem_access.sv */
`default_nettype none

module tb_mem_access;
    import mem_pkg::*;

    logic              clk;
    logic              rst;
    logic              clear;
    logic              trap_en;
    mem_op_e           mem_op;
    logic [XLEN-1:0]   pc;
    logic [4:0]        rd;
    logic [XLEN-1:0]   result;
    logic [XLEN-1:0]   data2;
    logic [XLEN-1:0]   csr_data;
    logic              op_csr;
    logic              invalid;
    logic [XLEN-1:0]   ma_out;
    logic [XLEN-1:0]   pc_out;
    logic [4:0]        rd_out;
    logic [XLEN-1:0]   data_out;
    logic              stall;
    logic              a_valid;
    tl_a_op_e          a_opcode;
    logic [SIZE_W-1:0] a_size;
    logic [XLEN-1:0]   a_address;
    logic [XLEN-1:0]   a_data;
    logic              a_ready;
    logic              d_valid;
    tl_d_op_e          d_opcode;
    logic [XLEN-1:0]   d_data;
    int                a_count;

    logic [XLEN-1:0] ref_mem [64];
    logic [7:0]      line_valid;    // lines the cache should hold.
    logic [2:0]      line_tag [8];
    logic            timed_out;
    int              errors;
    int              ops;

    mem_access DUT (.*);
    tl_mem_model u_mem (.*);

    always #4 clk = ~clk;

    task automatic report_fail(input string msg);
        errors++;
        $display("[FAIL] t=%0t: %s", $time, msg);
    endtask

    task automatic end_run();
        $display("ops retired %0d, errors %0d", ops, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    endtask

    // a channel fields while a_valid is up.
    task automatic check_request(input mem_op_e op, input logic [XLEN-1:0] addr,
                                 input logic [XLEN-1:0] sdata);
        logic            is_st;
        logic [XLEN-1:0] exp_addr;
        logic [XLEN-1:0] exp_data;
        is_st    = op inside {MEM_SD, MEM_SW};
        exp_addr = {addr[XLEN-1:3], 3'b000};
        exp_data = sdata;
        if (op == MEM_SW) begin
            exp_addr = {addr[XLEN-1:2], 2'b00};
            exp_data = addr[2] ? {sdata[31:0], 32'd0} : {32'd0, sdata[31:0]};
        end
        if (a_opcode !== (is_st ? TL_PUT_FULL : TL_GET)) begin
            report_fail($sformatf("%s: a_opcode %0d is wrong", op.name(), a_opcode));
        end
        if (a_size !== ((op == MEM_SW) ? 3'd2 : 3'd3)) begin
            report_fail($sformatf("%s: a_size %0d is wrong", op.name(), a_size));
        end
        if (a_address !== exp_addr) begin
            report_fail($sformatf("%s: a_address %h, expected %h",
                                  op.name(), a_address, exp_addr));
        end
        if (is_st && a_data !== exp_data) begin
            report_fail($sformatf("%s: a_data %h, expected %h",
                                  op.name(), a_data, exp_data));
        end
    endtask

    task automatic flush_cache();
        @(posedge clk);
        invalid <= 1'b1;
        @(posedge clk);
        invalid <= 1'b0;
        line_valid = '0;
    endtask

    function automatic logic [XLEN-1:0] pick_addr(input mem_op_e op);
        logic [XLEN-1:0] a;
        a = XLEN'($urandom % 64) << 3;
        if (op inside {MEM_LW, MEM_LWU, MEM_SW}) a[2] = 1'($urandom);   // either word.
        return a;
    endfunction

    // drive one op, wait for it to retire, then check what write-back got.
    task automatic issue_op(input mem_op_e op, input logic [XLEN-1:0] addr,
                            input logic csr, input logic clr, input logic trp,
                            input logic inv = 1'b0);
        logic [XLEN-1:0] sdata;
        logic [XLEN-1:0] csr_val;
        logic [XLEN-1:0] pc_val;
        logic [4:0]      rd_val;
        logic [XLEN-1:0] exp_ma;
        logic [XLEN-1:0] exp;
        logic [31:0]     word;
        logic [5:0]      di;
        logic [2:0]      li;
        logic            is_ld;
        logic            is_st;
        logic            want_bus;
        int              cnt0;
        int              waited;
        if (timed_out) return;
        sdata    = {$urandom, $urandom};
        csr_val  = {$urandom, $urandom};
        pc_val   = {$urandom, $urandom};
        rd_val   = 5'($urandom);
        di       = addr[8:3];
        li       = addr[5:3];
        is_ld    = op inside {MEM_LD, MEM_LW, MEM_LWU};
        is_st    = op inside {MEM_SD, MEM_SW};
        want_bus = is_st || (is_ld && !(line_valid[li] && line_tag[li] == addr[8:6]));
        word     = addr[2] ? ref_mem[di][63:32] : ref_mem[di][31:0];
        case (op)
            MEM_LD:  exp_ma = ref_mem[di];
            MEM_LW:  exp_ma = {{32{word[31]}}, word};
            MEM_LWU: exp_ma = {32'd0, word};
            default: exp_ma = addr;   // alu value passes.
        endcase
        if (csr) exp_ma = csr_val;
        exp = (clr || trp) ? '0 : exp_ma;   // bubble only in the MA/WB register.

        @(posedge clk);
        mem_op   <= op;
        result   <= addr;
        data2    <= sdata;
        csr_data <= csr_val;
        op_csr   <= csr;
        clear    <= clr;
        trap_en  <= trp;
        invalid  <= inv;   // held flush, so the line cannot be kept.
        pc       <= pc_val;
        rd       <= rd_val;
        @(negedge clk);
        cnt0 = a_count;
        if (stall !== want_bus) begin
            report_fail($sformatf("%s at %h: stall %b on entry, expected %b",
                                  op.name(), addr, stall, want_bus));
        end
        if (!want_bus && a_valid !== 1'b0) begin
            report_fail($sformatf("%s at %h: a_valid raised without a bus access",
                                  op.name(), addr));
        end
        waited = 0;
        while (stall === 1'b1 && waited < 200) begin
            if (a_valid === 1'b1) check_request(op, addr, sdata);
            @(negedge clk);
            waited++;
        end
        if (stall !== 1'b0) begin
            errors++;
            timed_out = 1'b1;
            $display("timeout: %s at %h did not leave stall within 200 cycles",
                     op.name(), addr);
            return;
        end
        ops++;
        if (ma_out !== exp_ma) begin
            report_fail($sformatf("%s at %h: ma_out %h, expected %h",
                                  op.name(), addr, ma_out, exp_ma));
        end
        if (a_count !== cnt0 + (want_bus ? 1 : 0)) begin
            report_fail($sformatf("%s at %h: %0d bus requests, expected %0d",
                                  op.name(), addr, a_count - cnt0, want_bus));
        end

        // reference memory and cache tags follow the op.
        if (op == MEM_SD) begin
            ref_mem[di] = sdata;
        end else if (op == MEM_SW && addr[2]) begin
            ref_mem[di][63:32] = sdata[31:0];
        end else if (op == MEM_SW) begin
            ref_mem[di][31:0] = sdata[31:0];
        end
        if (is_ld && want_bus) begin
            line_valid[li] = 1'b1;
            line_tag[li]   = addr[8:6];
        end
        if (inv) line_valid = '0;

        @(posedge clk);   // MA/WB captures here.
        mem_op  <= MEM_NONE;
        op_csr  <= 1'b0;
        clear   <= 1'b0;
        trap_en <= 1'b0;
        invalid <= 1'b0;
        @(negedge clk);
        if (data_out !== exp) begin
            report_fail($sformatf("%s at %h: data_out %h, expected %h",
                                  op.name(), addr, data_out, exp));
        end
        if (rd_out !== ((clr || trp) ? 5'd0 : rd_val)) begin
            report_fail($sformatf("%s at %h: rd_out %0d is wrong", op.name(), addr, rd_out));
        end
        if (pc_out !== pc_val) begin
            report_fail($sformatf("%s at %h: pc_out %h, expected %h",
                                  op.name(), addr, pc_out, pc_val));
        end
        if (a_valid !== 1'b0) begin
            report_fail($sformatf("%s at %h: a_valid still high after retire",
                                  op.name(), addr));
        end
    endtask

    initial begin
        mem_op_e         op;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] dw;
        logic            st;
        int unsigned     side;
        void'($urandom(32'had1e));
        errors     = 0;
        ops        = 0;
        timed_out  = 1'b0;
        clk        = 1'b0;
        rst        = 1'b1;
        clear      = 1'b0;
        trap_en    = 1'b0;
        mem_op     = MEM_NONE;
        pc         = '0;
        rd         = 5'h1f;   // nonzero so the reset value of rd_out shows.
        result     = '0;
        data2      = '0;
        csr_data   = '0;
        op_csr     = 1'b0;
        invalid    = 1'b0;
        line_valid = '0;
        for (int i = 0; i < 64; i++) begin
            ref_mem[i]   = {$urandom, $urandom};
            u_mem.mem[i] = ref_mem[i];
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        if (rd_out !== 5'd0 || stall !== 1'b0 || a_valid !== 1'b0) begin
            report_fail($sformatf("in reset rd_out %0d, stall %b, a_valid %b",
                                  rd_out, stall, a_valid));
        end
        @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < 40; i++) begin   // loads only.
            op = mem_op_e'(1 + $urandom % 3);
            issue_op(op, pick_addr(op), 1'b0, 1'b0, 1'b0);
        end

        for (int j = 0; j < 4; j++) begin   // hits, write-through, flush.
            a  = pick_addr(MEM_LW);
            dw = {a[XLEN-1:3], 3'b000};
            issue_op(MEM_LD, dw, 1'b0, 1'b0, 1'b0);
            issue_op(MEM_LW, a, 1'b0, 1'b0, 1'b0);
            issue_op(MEM_SW, a, 1'b0, 1'b0, 1'b0);
            issue_op(MEM_LWU, a, 1'b0, 1'b0, 1'b0);
            flush_cache();
            issue_op(MEM_LW, a, 1'b0, 1'b0, 1'b0);
            flush_cache();
            issue_op(MEM_SD, dw, 1'b0, 1'b0, 1'b0);
            issue_op(MEM_LD, dw, 1'b0, 1'b0, 1'b0);
        end

        for (int i = 0; i < 300; i++) begin   // everything mixed.
            op   = mem_op_e'($urandom % 6);
            a    = pick_addr(op);
            st   = op inside {MEM_SD, MEM_SW};
            side = $urandom % 12;
            if ($urandom % 16 == 0) flush_cache();
            issue_op(op, a, !st && side == 0, !st && side == 1, !st && side == 2,
                     !st && side == 3);
        end
        end_run();
    end

endmodule

`default_nettype wire

/* tb/tl_mem_model.sv */
`default_nettype none

module tl_mem_model (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       a_valid,
    input  mem_pkg::tl_a_op_e          a_opcode,
    input  logic [mem_pkg::SIZE_W-1:0] a_size,
    input  logic [mem_pkg::XLEN-1:0]   a_address,
    input  logic [mem_pkg::XLEN-1:0]   a_data,
    output logic                       a_ready,
    output logic                       d_valid,
    output mem_pkg::tl_d_op_e          d_opcode,
    output logic [mem_pkg::XLEN-1:0]   d_data,
    output int                         a_count
);
    import mem_pkg::*;

    logic [XLEN-1:0] mem [64];   // contents loaded by the testbench.
    logic            busy;
    int              delay;
    logic [5:0]      idx;

    assign idx = a_address[8:3];

    initial begin
        a_ready  = 1'b0;
        d_valid  = 1'b0;
        d_opcode = TL_ACK;
        d_data   = '0;
        a_count  = 0;
        busy     = 1'b0;
        delay    = 0;
    end

    // one request at a time, response after a random delay.
    always @(posedge clk) begin
        d_valid <= 1'b0;
        if (rst) begin
            a_ready <= 1'b0;
            busy    <= 1'b0;
        end else if (a_valid && a_ready) begin
            a_count <= a_count + 1;
            a_ready <= 1'b0;
            busy    <= 1'b1;
            delay   <= $urandom % 5;
            if (a_opcode == TL_GET) begin
                d_opcode <= TL_ACK_DATA;
                d_data   <= mem[idx];
            end else begin
                d_opcode <= TL_ACK;
                d_data   <= '0;
                if (a_size == SIZE_W'(3)) begin
                    mem[idx] <= a_data;
                end else if (a_address[2]) begin
                    mem[idx][63:32] <= a_data[63:32];   // upper word lane.
                end else begin
                    mem[idx][31:0] <= a_data[31:0];
                end
            end
        end else if (busy) begin
            if (delay == 0) begin
                d_valid <= 1'b1;
                busy    <= 1'b0;
            end else begin
                delay <= delay - 1;
            end
        end else begin
            a_ready <= ($urandom % 4) != 0;   // ready about three cycles in four.
        end
    end

endmodule

`default_nettype wire
